// File: cpu_pkg.sv
// Core package: word sizes, opcode enum, instruction fields, pipeline structs
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;              // Data and address width
    localparam int REG_ADDR_W = 5;               // 32 registers
    localparam int OPC_W      = 6;               // Opcode field width
    localparam int IMM_W      = 16;              // Immediate field width

    // Instruction field positions, LSB of each field
    localparam int OPC_LSB = 26;                 // Opcode, bits 31-26
    localparam int RD_LSB  = 21;                 // Destination, bits 25-21
    localparam int RS1_LSB = 16;                 // Source 1, bits 20-16
    localparam int RS2_LSB = 11;                 // Source 2, bits 15-11
    localparam int IMM_LSB = 0;                  // Immediate, bits 15-0

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_ADDI = 6'd6,                          // rd = rs1 + sext(imm)
        OP_LUI  = 6'd7,                          // rd = imm << 16
        OP_BEQ  = 6'd8,
        OP_BNE  = 6'd9
    } opcode_e;

    localparam word_t INSN_NOP = '0;             // All-zero word decodes as NOP

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        opcode_e   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      we;                           // Writes rd
        word_t     a;                            // rs1 value at decode
        word_t     b;                            // rs2 value at decode
        word_t     imm;                          // Already extended
    } decoded_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        opcode_e   op;
        logic      we;
        reg_addr_t rd;
        word_t     data;                         // ALU result
    } retire_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
// Fetch stage: program counter, instruction fetch register, branch redirect
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = '0       // First fetch address
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire logic           stall,            // Freeze pc and fetch_q
    input  wire logic           br_taken,         // Redirect from execute
    input  wire cpu_pkg::word_t br_addr,          // Branch target
    input  wire cpu_pkg::word_t imem_data,        // Same-cycle instruction
    output cpu_pkg::word_t      imem_addr,
    output cpu_pkg::fetch_t     fetch_q
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus4;

    assign pc_plus4  = pc + cpu_pkg::WORD_W'(4);
    assign imem_addr = pc;                        // Memory answers combinationally

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            fetch_q <= '0;                        // No valid instruction yet
        end else if (!stall) begin
            if (br_taken) begin
                pc            <= br_addr;         // Restart at target
                fetch_q.valid <= 1'b0;            // Squash wrong-path fetch
                fetch_q.pc    <= pc;
                fetch_q.insn  <= cpu_pkg::INSN_NOP;
            end else begin
                pc            <= pc_plus4;
                fetch_q.valid <= 1'b1;
                fetch_q.pc    <= pc;
                fetch_q.insn  <= imem_data;
            end
        end
        // Stall holds everything
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
// Decode stage: opcode map, immediate extension, register read, decode register
`default_nettype none

module decode_stage (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              stall,            // Hold dec_q
    input  wire logic              br_taken,         // Flush dec_q
    input  wire cpu_pkg::fetch_t   fetch_q,
    output cpu_pkg::reg_addr_t     raddr1,
    output cpu_pkg::reg_addr_t     raddr2,
    input  wire cpu_pkg::word_t    rdata1,           // Write-through already applied
    input  wire cpu_pkg::word_t    rdata2,
    output cpu_pkg::decoded_t      dec_q
);

    cpu_pkg::word_t              insn;
    logic [cpu_pkg::IMM_W-1:0]   imm16;
    cpu_pkg::opcode_e            op_raw;
    logic                        is_alu;
    cpu_pkg::decoded_t           dec_d;

    assign insn   = fetch_q.insn;
    assign imm16  = insn[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W];
    assign op_raw = cpu_pkg::opcode_e'(insn[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W]);
    assign raddr1 = insn[cpu_pkg::RS1_LSB +: cpu_pkg::REG_ADDR_W];
    assign raddr2 = insn[cpu_pkg::RS2_LSB +: cpu_pkg::REG_ADDR_W];

    always_comb begin
        dec_d       = '0;
        dec_d.valid = fetch_q.valid;
        dec_d.pc    = fetch_q.pc;
        dec_d.rd    = insn[cpu_pkg::RD_LSB +: cpu_pkg::REG_ADDR_W];
        dec_d.rs1   = raddr1;
        dec_d.rs2   = raddr2;
        dec_d.a     = rdata1;
        dec_d.b     = rdata2;

        case (op_raw)                                 // Undefined opcodes run as NOP
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_ADDI,
            cpu_pkg::OP_LUI, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: dec_d.op = op_raw;
            default:                                           dec_d.op = cpu_pkg::OP_NOP;
        endcase

        case (dec_d.op)
            cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR:
                dec_d.imm = {{(cpu_pkg::WORD_W-cpu_pkg::IMM_W){1'b0}}, imm16};   // Zero ext
            cpu_pkg::OP_LUI:
                dec_d.imm = {imm16, {(cpu_pkg::WORD_W-cpu_pkg::IMM_W){1'b0}}};   // Upper half
            default:
                dec_d.imm = {{(cpu_pkg::WORD_W-cpu_pkg::IMM_W){imm16[cpu_pkg::IMM_W-1]}},
                             imm16};                  // Sign ext, branches too
        endcase

        case (dec_d.op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_ADDI,
            cpu_pkg::OP_LUI: is_alu = 1'b1;
            default:         is_alu = 1'b0;
        endcase

        dec_d.we = is_alu && (dec_d.rd != '0);        // r0 writes dropped here
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_q <= '0;
        end else if (!stall) begin
            if (br_taken) begin
                dec_q <= '0;                          // Bubble behind taken branch
            end else begin
                dec_q <= dec_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
// Register file: 32 x 32, r0 reads zero, two read ports with write-through
`default_nettype none

module reg_file (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire cpu_pkg::reg_addr_t raddr1,
    input  wire cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t          rdata1,
    output cpu_pkg::word_t          rdata2,
    input  wire logic               we,
    input  wire cpu_pkg::reg_addr_t waddr,
    input  wire cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [1:31];                  // r0 not stored
    logic           wr_en;

    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                    // Known start state
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write bypasses the array
    assign rdata1 = (raddr1 == '0) ? '0 : (wr_en && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (wr_en && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: execute_stage.sv
// Execute stage: operand forwarding, ALU, branch compare and target
`default_nettype none

module execute_stage (
    input  wire cpu_pkg::decoded_t dec_q,
    input  wire cpu_pkg::retire_t  fwd,           // Retire register
    output cpu_pkg::retire_t       ex_out,
    output logic                   br_taken,
    output cpu_pkg::word_t         br_addr
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_res;
    logic           fwd_a;
    logic           fwd_b;
    logic           ops_eq;

    // Retire payload survives a stall bubble, so we alone qualifies forwarding
    assign fwd_a = fwd.we && (fwd.rd == dec_q.rs1);
    assign fwd_b = fwd.we && (fwd.rd == dec_q.rs2);
    assign op_a  = fwd_a ? fwd.data : dec_q.a;
    assign op_b  = fwd_b ? fwd.data : dec_q.b;

    always_comb begin
        case (dec_q.op)
            cpu_pkg::OP_ADD:  alu_res = op_a + op_b;
            cpu_pkg::OP_SUB:  alu_res = op_a - op_b;
            cpu_pkg::OP_AND:  alu_res = op_a & op_b;
            cpu_pkg::OP_OR:   alu_res = op_a | op_b;
            cpu_pkg::OP_XOR:  alu_res = op_a ^ op_b;
            cpu_pkg::OP_ADDI: alu_res = op_a + dec_q.imm;
            cpu_pkg::OP_LUI:  alu_res = dec_q.imm;       // Shifted in decode
            default:          alu_res = '0;              // NOP and branches
        endcase
    end

    assign ops_eq = (op_a == op_b);

    always_comb begin
        br_taken = 1'b0;
        if (dec_q.valid) begin                    // Bubbles never redirect
            case (dec_q.op)
                cpu_pkg::OP_BEQ: br_taken = ops_eq;
                cpu_pkg::OP_BNE: br_taken = !ops_eq;
                default:         br_taken = 1'b0;
            endcase
        end
    end

    // Word offset relative to the next instruction
    assign br_addr = dec_q.pc + cpu_pkg::WORD_W'(4)
                   + {dec_q.imm[cpu_pkg::WORD_W-3:0], 2'b00};

    always_comb begin
        ex_out       = '0;
        ex_out.valid = dec_q.valid;
        ex_out.pc    = dec_q.pc;
        ex_out.op    = dec_q.op;
        ex_out.we    = dec_q.valid && dec_q.we;   // Bubbles never write
        ex_out.rd    = dec_q.rd;
        ex_out.data  = alu_res;
    end

endmodule

`default_nettype wire

// File: result_stage.sv
// Result stage: retire register, register-file write port, retire report
`default_nettype none

module result_stage (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               stall,        // Load a bubble
    input  wire cpu_pkg::retire_t   ex_out,
    output logic                    we,
    output cpu_pkg::reg_addr_t      waddr,
    output cpu_pkg::word_t          wdata,
    output cpu_pkg::retire_t        ret           // Also the forwarding source
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret <= '0;
        end else if (stall) begin
            // Payload kept for forwarding to the held instruction in execute
            ret.valid <= 1'b0;
        end else begin
            ret <= ex_out;
        end
    end

    assign we    = ret.valid && ret.we;           // One write per retirement
    assign waddr = ret.rd;
    assign wdata = ret.data;

endmodule

`default_nettype wire

// File: cpu_core.sv
// Core top level: fetch, decode, execute and result stages with register file
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire logic           stall,            // Global freeze
    output cpu_pkg::word_t      imem_addr,
    input  wire cpu_pkg::word_t imem_data,
    output cpu_pkg::retire_t    ret               // One pulse per instruction
);

    cpu_pkg::fetch_t    fetch_q;
    cpu_pkg::decoded_t  dec_q;
    cpu_pkg::retire_t   ex_out;
    logic               br_taken;
    cpu_pkg::word_t     br_addr;
    cpu_pkg::reg_addr_t raddr1;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;
    logic               rf_we;
    cpu_pkg::reg_addr_t rf_waddr;
    cpu_pkg::word_t     rf_wdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk, .arst_n, .stall, .br_taken, .br_addr,
        .imem_data, .imem_addr, .fetch_q
    );

    decode_stage i_decode (
        .clk, .arst_n, .stall, .br_taken, .fetch_q,
        .raddr1, .raddr2, .rdata1, .rdata2, .dec_q
    );

    reg_file i_rf (
        .clk, .arst_n, .raddr1, .raddr2, .rdata1, .rdata2,
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    execute_stage i_execute (
        .dec_q,
        .fwd      (ret),                          // Forward from retire register
        .ex_out, .br_taken, .br_addr
    );

    result_stage i_result (
        .clk, .arst_n, .stall, .ex_out,
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .ret
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset generator for the core testbench
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,             // Clock period
    parameter int RESET_CYCLES = 10              // Rising edges with reset low
) (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;                          // Release away from the rising edge
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
// Random program, stall stimulus, ISA model, compare tasks and watchdog of the core testbench
`default_nettype none

module tb_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int             PERIOD_NS    = 40;
    localparam int             RESET_CYCLES = 10;
    localparam int             PROG_WORDS   = 64;
    localparam int             N_RETIRE     = 2000;
    localparam int             WATCHDOG_NS  = (10 * N_RETIRE + RESET_CYCLES) * PERIOD_NS;
    localparam cpu_pkg::word_t RESET_PC     = 32'h0000_0100;

    logic             clk;
    logic             arst_n;
    logic             stall = 1'b0;
    cpu_pkg::word_t   imem_addr;
    cpu_pkg::word_t   imem_data;
    cpu_pkg::retire_t ret;

    cpu_pkg::word_t   prog [PROG_WORDS];         // Program image
    logic [31:0]      lcg_state = 32'h7bda2ff9;
    cpu_pkg::word_t   m_regs [32];               // Model register file
    cpu_pkg::word_t   m_pc;                      // Model program counter
    logic             stalled_edge = 1'b0;       // Stall level at the last rising edge
    int               n_retired = 0;
    int               n_taken = 0;
    int               n_stalls = 0;
    int               n_errors = 0;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clk (
        .clk, .arst_n
    );

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk, .arst_n, .stall, .imem_addr, .imem_data, .ret
    );

    assign imem_data = prog[imem_addr[7:2]];     // Image repeats every 256 bytes

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Mostly r0 to r3 so that results feed the next few instructions
    function automatic cpu_pkg::reg_addr_t pick_reg();
        logic [31:0] r;
        r = lcg_next();
        if (r[31:29] == 3'd0) begin
            return r[28:24];                     // Any register
        end
        return {3'b000, r[28:27]};
    endfunction

    function automatic cpu_pkg::word_t make_insn();
        logic [31:0]        r;
        logic [31:0]        v;
        logic [5:0]         opc;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::reg_addr_t rs1;
        cpu_pkg::reg_addr_t rs2;
        r   = lcg_next();
        v   = lcg_next();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        case (r[31:28])
            4'd0:        opc = cpu_pkg::OP_NOP;
            4'd1, 4'd11: opc = cpu_pkg::OP_ADD;
            4'd2, 4'd12: opc = cpu_pkg::OP_SUB;
            4'd3:        opc = cpu_pkg::OP_AND;
            4'd4:        opc = cpu_pkg::OP_OR;
            4'd5, 4'd13: opc = cpu_pkg::OP_XOR;
            4'd6, 4'd10: opc = cpu_pkg::OP_ADDI;
            4'd7:        opc = cpu_pkg::OP_LUI;
            4'd8, 4'd15: opc = cpu_pkg::OP_BEQ;
            4'd9:        opc = cpu_pkg::OP_BNE;
            default:     opc = 6'd10 + 6'(r[11:0] % 12'd54);   // Undefined 10 to 63
        endcase
        if (opc == cpu_pkg::OP_ADDI || opc == cpu_pkg::OP_LUI) begin
            return {opc, rd, rs1, v[15:0]};
        end
        if (opc == cpu_pkg::OP_BEQ || opc == cpu_pkg::OP_BNE) begin
            // Short forward jumps in the image with the upper offset bits shared with rs2
            return {opc, rd, rs1, rs2, v[10:6], 3'b000, v[2:0]};
        end
        return {opc, rd, rs1, rs2, v[10:0]};
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input cpu_pkg::reg_addr_t got,
                             input cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s got r%0d expected r%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input cpu_pkg::opcode_e got,
                            input cpu_pkg::opcode_e exp);
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s got %s (%0d) expected %s (%0d)",
                     $time, name, got.name(), got, exp.name(), exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // One ISA step per retirement with a field by field compare
    task automatic retire_check();
        cpu_pkg::word_t     insn;
        cpu_pkg::word_t     a;
        cpu_pkg::word_t     b;
        cpu_pkg::word_t     imm_s;
        cpu_pkg::word_t     res;
        cpu_pkg::word_t     next_pc;
        cpu_pkg::opcode_e   op;
        cpu_pkg::reg_addr_t rd;
        logic [5:0]         opc;
        logic               is_alu;
        logic               taken;
        logic               wr;
        insn    = prog[m_pc[7:2]];
        opc     = insn[31:26];
        rd      = insn[25:21];
        a       = m_regs[insn[20:16]];
        b       = m_regs[insn[15:11]];
        imm_s   = {{16{insn[15]}}, insn[15:0]};
        op      = (opc <= 6'd9) ? cpu_pkg::opcode_e'(opc) : cpu_pkg::OP_NOP;
        res     = '0;
        is_alu  = 1'b1;
        taken   = 1'b0;
        case (op)
            cpu_pkg::OP_ADD:  res = a + b;
            cpu_pkg::OP_SUB:  res = a - b;
            cpu_pkg::OP_AND:  res = a & b;
            cpu_pkg::OP_OR:   res = a | b;
            cpu_pkg::OP_XOR:  res = a ^ b;
            cpu_pkg::OP_ADDI: res = a + imm_s;
            cpu_pkg::OP_LUI:  res = {insn[15:0], 16'h0000};
            cpu_pkg::OP_BEQ: begin
                is_alu = 1'b0;
                taken  = (a == b);
            end
            cpu_pkg::OP_BNE: begin
                is_alu = 1'b0;
                taken  = (a != b);
            end
            default:          is_alu = 1'b0;             // NOP and undefined
        endcase
        next_pc = taken ? m_pc + 32'd4 + (imm_s << 2) : m_pc + 32'd4;
        wr      = is_alu && (rd != 5'd0);
        check_word("ret.pc", ret.pc, m_pc);
        check_op("ret.op", ret.op, op);
        check_bit("ret.we", ret.we, wr);
        if (is_alu) begin
            check_reg("ret.rd", ret.rd, rd);
            check_word("ret.data", ret.data, res);
        end
        if (wr) begin
            m_regs[rd] = res;                    // r0 never written
        end
        if (taken) begin
            n_taken++;
        end
        m_pc = next_pc;
        n_retired++;
    endtask

    task automatic print_summary();
        $display("summary: %0d retired, %0d taken branches, %0d stall cycles, %0d errors",
                 n_retired, n_taken, n_stalls, n_errors);
    endtask

    // Program image first and a new stall level on each rising edge after reset
    initial begin
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = make_insn();
        end
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            stall <= (lcg_next() < 32'h4000_0000);   // About 1 cycle in 4
        end
    end

    // Monitor and reference model
    initial begin
        m_pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        @(posedge clk);                          // Flops reset by now
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            #1;
            if (arst_n !== 1'b1) begin
                check_bit("ret.valid", ret.valid, 1'b0);
                check_word("imem_addr", imem_addr, RESET_PC);
            end
        end
        check_bit("ret.valid", ret.valid, 1'b0); // Just after release
        check_word("imem_addr", imem_addr, RESET_PC);
        forever begin
            @(negedge clk);
            if (stalled_edge) begin
                n_stalls++;
                check_bit("ret.valid", ret.valid, 1'b0);
            end
            if (ret.valid) begin
                retire_check();
            end
            stalled_edge = stall;                // Sampled by the coming edge
        end
    end

    initial begin
        wait (n_retired >= N_RETIRE);
        print_summary();
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: retirement stopped after %0d of %0d instructions",
                 n_retired, N_RETIRE);
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
result_stage.sv
cpu_core.sv
tb_clock_gen.sv
tb_cpu.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_cpu
FILELIST := verilog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard *.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
